//--- Makefile
# Verilator build and run of the ADXL355 PPS sync testbench

SRCS := $(shell grep -v '^+' src.f)

all: run

obj_dir/Vtb_adxl355_pps_sync: src.f $(SRCS)
	verilator --binary --timing -Wno-fatal -f src.f --top-module tb_adxl355_pps_sync -j 0

sim.log: obj_dir/Vtb_adxl355_pps_sync
	./obj_dir/Vtb_adxl355_pps_sync > sim.log 2>&1 || true

run: sim.log
	@cat sim.log
	@grep -q '^\*\* PASS \*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

//--- hw/adxl355_pps_sync_top.sv
`timescale 1ns/1ps
/*
  PPS-disciplined DRDY/SYNC for the ADXL355 logger, single clock domain
  pps_in, trims and FTDI lines are asynchronous; only pps_in is synchronized
  SD lanes come out as value plus enable, tristate at the pads
*/
module adxl355_pps_sync_top #(
  parameter int unsigned clk_hz            = 40_000_000,
  parameter int unsigned pps_n             = 1,
  parameter int unsigned pps_s             = 1,
  parameter int unsigned pps_tol_cyc       = 20_000,  // 500 us at 40 MHz
  parameter int unsigned sync_hz           = 1000,    // sensor sample rate
  parameter int unsigned pa_bits           = 30,
  parameter int unsigned prog_timeout_bits = 26       // about 1.7 s at 40 MHz
) (
  input  logic                                  clk,
  input  logic                                  arst_n,
  input  logic                                  pps_in,
  input  logic                                  faster,
  input  logic                                  slower,
  input  logic                                  hold_gpio0,
  input  logic                                  ftdi_ndtr,
  input  logic                                  ftdi_nrts,
  input  logic                                  ftdi_txd,
  input  logic                                  wifi_txd,
  input  logic                                  esp_csn,
  input  logic                                  esp_mosi,
  input  logic                                  esp_sclk,
  input  logic                                  adxl_miso,
  output logic                                  drdy,
  output logic [adxl_sync_pkg::phase_mon_w-1:0] phase,
  output logic                                  pps_valid,
  output logic                                  sync_locked,
  output logic [adxl_sync_pkg::sync_cnt_w-1:0]  sync_count,
  output logic                                  pps_feedback,
  output logic                                  ftdi_rxd,
  output logic                                  wifi_rxd,
  output logic                                  wifi_en,
  output logic                                  wifi_gpio0,
  output logic [3:0]                            sd_d,
  output logic                                  sd_oe,
  output logic                                  adxl_csn,
  output logic                                  adxl_mosi,
  output logic                                  adxl_sclk,
  output logic                                  esp_miso
);

  logic pps_edge;

  // serial and SPI straight through, ESP32 is SPI master
  assign ftdi_rxd     = wifi_txd;
  assign wifi_rxd     = ftdi_txd;
  assign adxl_csn     = esp_csn;
  assign adxl_mosi    = esp_mosi;
  assign adxl_sclk    = esp_sclk;
  assign esp_miso     = adxl_miso;
  assign pps_feedback = pps_in;  // ESP32 watches its own PPS

  pps_checker #(
    .clk_hz(clk_hz), .pps_n(pps_n), .pps_s(pps_s), .pps_tol_cyc(pps_tol_cyc)
  ) u_pps_checker (
    .clk(clk), .arst_n(arst_n), .pps_in(pps_in),
    .pps_edge(pps_edge), .pps_valid(pps_valid)
  );

  sync_nco #(
    .clk_hz(clk_hz), .pps_n(pps_n), .pps_s(pps_s),
    .sync_hz(sync_hz), .pa_bits(pa_bits)
  ) u_sync_nco (
    .clk(clk), .arst_n(arst_n), .pps_edge(pps_edge), .pps_valid(pps_valid),
    .faster(faster), .slower(slower),
    .sync(drdy), .phase(phase), .sync_locked(sync_locked)
  );

  sync_period_counter u_sync_period_counter (
    .clk(clk), .arst_n(arst_n), .pps_edge(pps_edge), .sync(drdy),
    .sync_count(sync_count)
  );

  esp32_prog_ctrl #(
    .prog_timeout_bits(prog_timeout_bits)
  ) u_esp32_prog_ctrl (
    .clk(clk), .arst_n(arst_n), .ftdi_ndtr(ftdi_ndtr), .ftdi_nrts(ftdi_nrts),
    .hold_gpio0(hold_gpio0), .wifi_en(wifi_en), .wifi_gpio0(wifi_gpio0),
    .sd_d(sd_d), .sd_oe(sd_oe)
  );

endmodule

//--- hw/adxl_sync_pkg.sv
/*
  shared widths and ESP32 programming pin codes for the ADXL355 sync logger
  codes are {en, io0}; both pins are active low on the ESP32 side
*/
package adxl_sync_pkg;

  // monitor and counter widths
  localparam int unsigned phase_mon_w = 8;   // top accumulator bits shown as phase
  localparam int unsigned sync_cnt_w  = 12;  // enough for 4095 SYNC per interval

  // {en, io0} codes for the ESP32
  localparam logic [1:0] prog_run   = 2'b11; // normal run, both released
  localparam logic [1:0] prog_boot  = 2'b10; // io0 low, boot to serial download
  localparam logic [1:0] prog_reset = 2'b01; // en low, chip held in reset

  // strap bits on sd_d[3:1] (gpio13, gpio12, gpio4) while programming
  // gpio12 must stay low with unprogrammed efuse
  localparam logic [2:0] strap_boot = 3'b101;

endpackage

//--- hw/esp32_prog_ctrl.sv
`timescale 1ns/1ps
/*
  ESP32 auto-program glue: FTDI DTR/RTS to EN/IO0, BTN0 can hold io0 low
  SD lane straps are driven for 2^prog_timeout_bits cycles after boot entry
  sd_d is only meaningful while sd_oe is high, pads must tristate otherwise
*/
module esp32_prog_ctrl #(
  parameter int unsigned prog_timeout_bits = 26
) (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       ftdi_ndtr,
  input  logic       ftdi_nrts,
  input  logic       hold_gpio0,
  output logic       wifi_en,
  output logic       wifi_gpio0,
  output logic [3:0] sd_d,
  output logic       sd_oe
);

  logic [1:0]                 prog_in;
  logic [1:0]                 prog_in_prev;
  logic [1:0]                 prog_out;     // {en, io0}
  logic [prog_timeout_bits:0] release_tmr;  // top bit set = released

  assign prog_in = {ftdi_ndtr, ftdi_nrts};

  // usual nodemcu two-transistor mapping
  always_comb
  begin
    case (prog_in)
      2'b10:   prog_out = adxl_sync_pkg::prog_reset;
      2'b01:   prog_out = adxl_sync_pkg::prog_boot;
      default: prog_out = adxl_sync_pkg::prog_run;  // 00 and 11
    endcase
  end

  assign wifi_en    = prog_out[1];
  assign wifi_gpio0 = prog_out[0] & hold_gpio0;  // button low forces io0 low

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      prog_in_prev <= 2'b00;  // needs an idle 11 before a boot entry counts
      release_tmr  <= {1'b1, {prog_timeout_bits{1'b0}}};
    end
    else
    begin
      prog_in_prev <= prog_in;
      if (prog_out == adxl_sync_pkg::prog_boot && prog_in_prev == 2'b11)
        release_tmr <= '0;    // restart on boot entry
      else if (!release_tmr[prog_timeout_bits])
        release_tmr <= release_tmr + 1'b1;
    end
  end

  // gpio2 must follow gpio0 in download mode
  assign sd_oe = ~release_tmr[prog_timeout_bits];
  assign sd_d  = {adxl_sync_pkg::strap_boot, prog_out[0]};

endmodule

//--- hw/pps_checker.sv
`timescale 1ns/1ps
/*
  PPS edge detector and interval check, two-flop synchronizer on pps_in
  pps_edge comes 3 cycles after the pin edge; the first edge after reset
  is always judged invalid since there is no previous edge to measure from
*/
module pps_checker #(
  parameter int unsigned clk_hz      = 40_000_000,
  parameter int unsigned pps_n       = 1,
  parameter int unsigned pps_s       = 1,
  parameter int unsigned pps_tol_cyc = 20_000
) (
  input  logic clk,
  input  logic arst_n,
  input  logic pps_in,
  output logic pps_edge,
  output logic pps_valid
);

  // nominal interval in clk cycles, 64 bit to avoid overflow of clk_hz*pps_s
  localparam longint unsigned nom_cyc = 64'(clk_hz) * 64'(pps_s) / 64'(pps_n);
  localparam longint unsigned lo_cyc  = nom_cyc - 64'(pps_tol_cyc);
  localparam longint unsigned hi_cyc  = nom_cyc + 64'(pps_tol_cyc);
  localparam int unsigned     cnt_w   = $clog2(hi_cyc + 2); // holds hi_cyc+1

  localparam logic [cnt_w-1:0] lo_c = cnt_w'(lo_cyc);
  localparam logic [cnt_w-1:0] hi_c = cnt_w'(hi_cyc);

  logic             pps_meta;  // first sync stage
  logic             pps_sync;  // second sync stage
  logic             pps_prev;  // for edge detect
  logic             rise;
  logic [cnt_w-1:0] ivl_cnt;   // cycles since last edge, saturates at hi_c+1

  assign rise = pps_sync & ~pps_prev;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      pps_meta  <= 1'b0;
      pps_sync  <= 1'b0;
      pps_prev  <= 1'b0;
      pps_edge  <= 1'b0;
      pps_valid <= 1'b0;
      ivl_cnt   <= hi_c + 1'b1; // start out of range
    end
    else
    begin
      pps_meta <= pps_in;
      pps_sync <= pps_meta;
      pps_prev <= pps_sync;
      pps_edge <= rise;         // 3rd cycle after pin edge
      if (rise)
      begin
        // count here equals the interval, since restart loads 1
        pps_valid <= (ivl_cnt >= lo_c) && (ivl_cnt <= hi_c);
        ivl_cnt   <= cnt_w'(1);
      end
      else if (ivl_cnt <= hi_c)
        ivl_cnt <= ivl_cnt + 1'b1;
      else
        pps_valid <= 1'b0;      // edge missing or late
    end
  end

endmodule

//--- hw/sync_nco.sv
`timescale 1ns/1ps
/*
  phase accumulator SYNC/DRDY generator disciplined by accepted PPS edges
  SYNC rising edge is steered onto pps_edge (3 cycles behind the pin)
  pa_bits must be larger than phase_mon_w and the PPS interval in cycles
  must fit below 2^pa_bits; sync_hz below clk_hz/2
*/
module sync_nco #(
  parameter int unsigned clk_hz  = 40_000_000,
  parameter int unsigned pps_n   = 1,
  parameter int unsigned pps_s   = 1,
  parameter int unsigned sync_hz = 1000,
  parameter int unsigned pa_bits = 30
) (
  input  logic                                   clk,
  input  logic                                   arst_n,
  input  logic                                   pps_edge,
  input  logic                                   pps_valid,
  input  logic                                   faster,
  input  logic                                   slower,
  output logic                                   sync,
  output logic [adxl_sync_pkg::phase_mon_w-1:0]  phase,
  output logic                                   sync_locked
);

  // cycles per PPS interval, sets the frequency loop gain
  localparam longint unsigned ivl_cyc = 64'(clk_hz) * 64'(pps_s) / 64'(pps_n);
  // shift so that err/2^corr_sh is between 0.5 and 1 of err/ivl_cyc
  localparam int unsigned     corr_sh = $clog2(ivl_cyc);
  // rounded sync_hz * 2^pa_bits / clk_hz
  localparam logic [pa_bits-1:0] inc_nom =
    pa_bits'(((64'(sync_hz) << pa_bits) + 64'(clk_hz / 2)) / 64'(clk_hz));

  logic        [pa_bits-1:0] acc;       // phase accumulator
  logic        [pa_bits-1:0] inc;       // current increment, trimmed per PPS
  logic        [pa_bits-1:0] step;      // increment plus manual trim
  logic signed [pa_bits-1:0] ph_err;    // distance from SYNC rising edge
  logic signed [pa_bits-1:0] half_err;
  logic signed [pa_bits-1:0] freq_err;
  logic                      corr;      // accepted PPS edge this cycle
  logic                      in_win;
  logic                      win_prev;  // previous valid edge was in window

  // acc minus half scale, read signed
  // zero when the MSB has just risen
  assign ph_err   = {~acc[pa_bits-1], acc[pa_bits-2:0]};
  assign half_err = ph_err >>> 1;        // phase step, halfway to zero
  assign freq_err = ph_err >>> corr_sh;  // about err per interval cycle
  assign corr     = pps_edge & pps_valid;

  // |ph_err| below a quarter period, i.e. acc in [1/4, 3/4) of full scale
  assign in_win = acc[pa_bits-1] ^ acc[pa_bits-2];

  // one LSB per cycle while a trim input is held, both cancel
  assign step = inc + pa_bits'(faster) - pa_bits'(slower);

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      acc <= '0;
      inc <= inc_nom;
    end
    else if (corr)
    begin
      acc <= acc + step - $unsigned(half_err);
      inc <= inc - $unsigned(freq_err);  // used from next cycle
    end
    else
      acc <= acc + step;
  end

  // lock needs two valid edges in a row inside the window
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      win_prev    <= 1'b0;
      sync_locked <= 1'b0;
    end
    else if (!pps_valid)
    begin
      win_prev    <= 1'b0;  // lost or bad PPS
      sync_locked <= 1'b0;
    end
    else if (pps_edge)
    begin
      if (in_win)
      begin
        win_prev    <= 1'b1;
        sync_locked <= win_prev;
      end
      else
      begin
        win_prev    <= 1'b0;
        sync_locked <= 1'b0;
      end
    end
  end

  assign sync  = acc[pa_bits-1];  // 50% duty SYNC/DRDY
  assign phase = acc[pa_bits-1 -: adxl_sync_pkg::phase_mon_w];

endmodule

//--- hw/sync_period_counter.sv
`timescale 1ns/1ps
/*
  SYNC pulses per PPS interval, for monitoring only
  counts SYNC falling edges, half a period away from the PPS-aligned rise
  running count saturates, sync_count holds the last full interval
*/
module sync_period_counter (
  input  logic                                  clk,
  input  logic                                  arst_n,
  input  logic                                  pps_edge,
  input  logic                                  sync,
  output logic [adxl_sync_pkg::sync_cnt_w-1:0]  sync_count
);

  logic                                 sync_prev;
  logic                                 sync_fall;
  logic [adxl_sync_pkg::sync_cnt_w-1:0] run_cnt;  // falls since last PPS

  assign sync_fall = sync_prev & ~sync;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      sync_prev  <= 1'b0;
      run_cnt    <= '0;
      sync_count <= '0;
    end
    else
    begin
      sync_prev <= sync;
      if (pps_edge)
      begin
        sync_count <= run_cnt;            // visible 1 cycle after pps_edge
        run_cnt    <= '0;
        run_cnt[0] <= sync_fall;          // keep a fall on the edge cycle
      end
      else if (sync_fall && !(&run_cnt))
        run_cnt <= run_cnt + 1'b1;
    end
  end

endmodule

//--- src.f
hw/adxl_sync_pkg.sv
hw/pps_checker.sv
hw/sync_nco.sv
hw/sync_period_counter.sv
hw/esp32_prog_ctrl.sv
hw/adxl355_pps_sync_top.sv
tb/tb_adxl355_pps_sync.sv

//--- tb/tb_adxl355_pps_sync.sv
`timescale 1ns/1ps
/*
  testbench for adxl355_pps_sync_top, scaled to 20 kHz clock, 100 Hz SYNC
  one PPS interval is 20000 cycles, all stimulus from a seeded LCG
*/
module tb_adxl355_pps_sync;

  localparam int unsigned clk_hz  = 20000;
  localparam int unsigned sync_hz = 100;
  localparam int unsigned pa_bits = 20;
  localparam int unsigned nom_ivl = 20000;   // pps_n = pps_s = 1

  logic clk = 1'b0;
  logic arst_n, pps_in, faster, slower, hold_gpio0, ftdi_ndtr, ftdi_nrts;
  logic ftdi_txd, wifi_txd, esp_csn, esp_mosi, esp_sclk, adxl_miso;
  logic drdy, pps_valid, sync_locked, pps_feedback, ftdi_rxd, wifi_rxd;
  logic wifi_en, wifi_gpio0, sd_oe, adxl_csn, adxl_mosi, adxl_sclk, esp_miso;
  logic [7:0]  phase;
  logic [11:0] sync_count;
  logic [3:0]  sd_d;

  int unsigned lcg_state = 63885;
  int unsigned val_errors = 0;     // wrong values
  int unsigned tmo_errors = 0;     // waits that ran out
  logic [pa_bits-1:0] ref_acc;     // model accumulator for free run
  bit          nco_check = 0;
  bit          edge_seen, valid_at_edge, locked_after_edge;
  int unsigned count_after_edge;

  adxl355_pps_sync_top #(
    .clk_hz(clk_hz), .pps_n(1), .pps_s(1), .pps_tol_cyc(200),
    .sync_hz(sync_hz), .pa_bits(pa_bits), .prog_timeout_bits(6)
  ) UUT (
    .clk(clk), .arst_n(arst_n), .pps_in(pps_in), .faster(faster), .slower(slower),
    .hold_gpio0(hold_gpio0), .ftdi_ndtr(ftdi_ndtr), .ftdi_nrts(ftdi_nrts),
    .ftdi_txd(ftdi_txd), .wifi_txd(wifi_txd), .esp_csn(esp_csn),
    .esp_mosi(esp_mosi), .esp_sclk(esp_sclk), .adxl_miso(adxl_miso),
    .drdy(drdy), .phase(phase), .pps_valid(pps_valid), .sync_locked(sync_locked),
    .sync_count(sync_count), .pps_feedback(pps_feedback), .ftdi_rxd(ftdi_rxd),
    .wifi_rxd(wifi_rxd), .wifi_en(wifi_en), .wifi_gpio0(wifi_gpio0),
    .sd_d(sd_d), .sd_oe(sd_oe), .adxl_csn(adxl_csn), .adxl_mosi(adxl_mosi),
    .adxl_sclk(adxl_sclk), .esp_miso(esp_miso)
  );

  always #20 clk = ~clk;  // 40 ns period

  function automatic int unsigned rand_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return (lcg_state >> 16) & 32'h7fff;  // upper bits, low ones are poor
  endfunction

  // sync_hz * 2^pa_bits / clk_hz, rounded
  function automatic logic [pa_bits-1:0] nominal_inc();
    longint unsigned num;
    num = (longint'(sync_hz) << pa_bits) + clk_hz / 2;
    return pa_bits'(num / clk_hz);
  endfunction

  function automatic logic [pa_bits-1:0] nco_next(input logic [pa_bits-1:0] acc,
                                                  input logic f, input logic s);
    return acc + nominal_inc() + pa_bits'(f) - pa_bits'(s);
  endfunction

  // {en, io0} table for the DTR/RTS transistor pair
  function automatic logic [1:0] prog_map(input logic ndtr, input logic nrts,
                                          input logic hold);
    logic [1:0] r;
    case ({ndtr, nrts})
      2'b10:   r = 2'b01;  // en low, chip in reset
      2'b01:   r = 2'b10;  // io0 low, serial download
      default: r = 2'b11;
    endcase
    return {r[1], r[0] & hold};
  endfunction

  task automatic check_value(input string name, input int unsigned exp,
                             input int unsigned act);
    assert (exp == act)
    else
    begin
      val_errors++;
      $display("ERROR %s expected %0h actual %0h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic report_timeout(input string what);
    tmo_errors++;
    $display("timeout: %s at %0t", what, $time);
  endtask

  // reference accumulator, reads trims before this edge's stimulus lands
  always @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      ref_acc <= '0;
    else
      ref_acc <= nco_next(ref_acc, faster, slower);
  end

  always @(negedge clk)
  begin
    if (nco_check)
    begin
      check_value("free run phase", ref_acc[pa_bits-1 -: 8], phase);
      check_value("free run drdy", ref_acc[pa_bits-1], drdy);
    end
  end

  // one PPS pulse, then the rest of an ivl cycle interval
  task automatic send_pps(input int unsigned ivl);
    edge_seen = 0;
    for (int unsigned c = 0; c < ivl; c++)
    begin
      @(posedge clk);
      if (c == 0)
        pps_in <= 1'b1;
      if (c == 10)
        pps_in <= 1'b0;
      @(negedge clk);
      if (c < 12)
        check_value("pps_feedback", pps_in, pps_feedback);
      if (pps_edge_now() && !edge_seen)
      begin
        edge_seen     = 1;
        valid_at_edge = pps_valid;
        @(posedge clk);     // count shows one cycle later
        @(negedge clk);
        c++;
        count_after_edge  = sync_count;
        locked_after_edge = sync_locked;
      end
    end
    if (!edge_seen)
      report_timeout("no pps_edge after a PPS pulse");
  endtask

  function automatic logic pps_edge_now();
    return UUT.pps_edge;
  endfunction

  initial
  begin
    int unsigned n1, n2, hold_cyc, jp, jn, k;
    arst_n = 1'b0;
    pps_in = 1'b0;
    faster = 1'b0;
    slower = 1'b0;
    hold_gpio0 = 1'b1;
    ftdi_ndtr = 1'b1;
    ftdi_nrts = 1'b1;
    ftdi_txd = 1'b1;
    wifi_txd = 1'b1;
    esp_csn = 1'b1;
    esp_mosi = 1'b0;
    esp_sclk = 1'b0;
    adxl_miso = 1'b0;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check_value("sd_oe after reset", 0, sd_oe);

    // free run with random trim pulses
    nco_check = 1;
    for (int i = 0; i < 40; i++)
    begin
      @(posedge clk);
      faster <= 1'(rand_next() % 2);
      slower <= rand_next() % 3 == 0;
      hold_cyc = 1 + rand_next() % 20;
      repeat (hold_cyc) @(posedge clk);
      faster <= 1'b0;
      slower <= 1'b0;
      repeat (1 + rand_next() % 10) @(posedge clk);
    end
    @(negedge clk);
    nco_check = 0;

    // programming map and passthroughs
    for (int i = 0; i < 64; i++)
    begin
      @(posedge clk);
      {ftdi_ndtr, ftdi_nrts, hold_gpio0} <= 3'(rand_next());
      {ftdi_txd, wifi_txd, esp_csn} <= 3'(rand_next());
      {esp_mosi, esp_sclk, adxl_miso} <= 3'(rand_next());
      @(negedge clk);
      check_value("prog map", prog_map(ftdi_ndtr, ftdi_nrts, hold_gpio0),
                  {wifi_en, wifi_gpio0});
      check_value("ftdi_rxd", wifi_txd, ftdi_rxd);
      check_value("wifi_rxd", ftdi_txd, wifi_rxd);
      check_value("adxl_csn", esp_csn, adxl_csn);
      check_value("adxl_mosi", esp_mosi, adxl_mosi);
      check_value("adxl_sclk", esp_sclk, adxl_sclk);
      check_value("esp_miso", adxl_miso, esp_miso);
    end

    // strap release after 11 to boot entry
    @(posedge clk);
    {ftdi_ndtr, ftdi_nrts, hold_gpio0} <= 3'b111;
    k = 0;
    while (sd_oe && k < 64 + 8)  // let a random boot entry run out first
    begin
      @(negedge clk);
      k++;
    end
    if (sd_oe)
      report_timeout("sd_oe stayed high with the lines idle");
    repeat (2) @(posedge clk);
    {ftdi_ndtr, ftdi_nrts} <= 2'b01;
    @(posedge clk);
    @(negedge clk);
    check_value("sd_oe in boot", 1, sd_oe);
    check_value("sd_d in boot", 4'b1010, sd_d);   // 101 straps, io0 low
    k = 0;
    while (sd_oe && k < 64 + 8)
    begin
      @(negedge clk);
      k++;
    end
    if (sd_oe)
      report_timeout("sd_oe never released");
    @(posedge clk);
    {ftdi_ndtr, ftdi_nrts} <= 2'b11;

    // PPS validity
    check_value("sync_count before pps", 0, sync_count);
    n1 = nom_ivl - 150 + rand_next() % 301;
    n2 = nom_ivl - 150 + rand_next() % 301;
    send_pps(n1);
    send_pps(n2);
    check_value("pps_valid second edge", 1, valid_at_edge);
    send_pps(nom_ivl + 500);
    check_value("pps_valid before long", 1, valid_at_edge);
    send_pps(nom_ivl);
    check_value("pps_valid long interval", 0, valid_at_edge);
    send_pps(nom_ivl);
    check_value("pps_valid after long", 1, valid_at_edge);
    k = 0;
    while (pps_valid && k < nom_ivl + 1000)
    begin
      @(negedge clk);
      k++;
    end
    if (pps_valid)
      report_timeout("pps_valid stayed high with PPS missing");

    // lock with small jitter around a fixed grid, then count
    jp = 8;
    locked_after_edge = 0;
    k = 0;
    while (!locked_after_edge && k < 15)
    begin
      jn = rand_next() % 17;       // 0..16, grid offset 8
      send_pps(nom_ivl + jn - jp);
      jp = jn;
      k++;
    end
    if (!locked_after_edge)
      report_timeout("sync_locked not set within 15 intervals");
    for (int i = 0; i < 4; i++)
    begin
      jn = rand_next() % 17;
      send_pps(nom_ivl + jn - jp);
      jp = jn;
      if (locked_after_edge)
        check_value("sync_count locked", 100, count_after_edge);
    end

    $display("errors: %0d value, %0d timeout", val_errors, tmo_errors);
    if (val_errors == 0 && tmo_errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule
